//--- design/data_memory_macros.svh
/*
 * Sizing constants for the L1 data array, the load response queue and
 * the response credit loop. Include this header wherever one of the
 * sizes is needed, and the package derives its field widths from it.
 */

`ifndef DATA_MEMORY_MACROS_SVH
`define DATA_MEMORY_MACROS_SVH

// --------------------
// Data array geometry
// --------------------

// Number of 32-bit banks, selected by the low word address bits
`define DCACHE_BANKS 4

// Words held by each bank
`define DCACHE_DEPTH 64

// --------------------
// Load return path
// --------------------

// Entries in the load response FIFO, which is also the number of
// load slots the access unit may reserve at once
`define LOAD_QUEUE_DEPTH 4

// Response credits the queue holds right after reset
`define RESP_CREDIT_INIT 2

`endif

//--- design/data_memory_pkg.sv
/*
 * Shared types of the data cache subsystem. Holds the memory opcode,
 * the incoming request and the bank access and load descriptor structs
 * passed between the access unit, the data block and the load queue.
 */

`include "data_memory_macros.svh"

package data_memory_pkg;

    // Field widths follow from the sizes in the macro header
    localparam int BANK_SEL_W = $clog2(`DCACHE_BANKS);
    localparam int INDEX_W    = $clog2(`DCACHE_DEPTH);
    localparam int ADDR_W     = 2 + BANK_SEL_W + INDEX_W;

    // Loads first, then stores, in RISC-V funct3 order within each group
    typedef enum logic [2:0] {
        OP_LB,
        OP_LH,
        OP_LW,
        OP_LBU,
        OP_LHU,
        OP_SB,
        OP_SH,
        OP_SW
    } mem_op_t;

    typedef struct packed {
        mem_op_t           op;
        logic [ADDR_W-1:0] addr;
        logic [31:0]       wdata;
    } mem_req_t;

    typedef logic [BANK_SEL_W-1:0] bank_select_t;
    typedef logic [INDEX_W-1:0]    dcache_index_t;
    typedef logic [3:0]            byte_write_t;

    // Write side of the banked array
    typedef struct packed {
        logic          write;
        bank_select_t  bank_select;
        dcache_index_t index;
        byte_write_t   byte_write;
        logic [31:0]   data;
    } bank_write_t;

    // Read side of the banked array
    typedef struct packed {
        logic          read;
        bank_select_t  bank_select;
        dcache_index_t index;
    } bank_read_t;

    // A load in flight, so the queue knows how to shape the returned word
    typedef struct packed {
        logic       valid;
        mem_op_t    op;
        logic [1:0] offset;
    } load_desc_t;

endpackage

//--- design/data_memory_bank.sv
/*
 * A single 32-bit wide bank of the data array. Port 0 writes any mix of
 * byte lanes under a mask, port 1 reads a word into an output register
 * so the data appears on the cycle after the read request.
 */

`timescale 1ns/1ps

`include "data_memory_macros.svh"

module data_memory_bank
    import data_memory_pkg::*;
(
    input  logic          clk_i,

    // Write port
    input  logic          port0_write_i,
    input  byte_write_t   port0_byte_write_i,
    input  dcache_index_t port0_address_i,
    input  logic [31:0]   port0_data_i,

    // Read port
    input  logic          port1_read_i,
    input  dcache_index_t port1_address_i,
    output logic [31:0]   port1_data_o
);

    // One 32-bit word per index of the bank
    logic [31:0] mem_array [`DCACHE_DEPTH];

    // --------------------
    // Byte lane writes
    // --------------------

    always_ff @(posedge clk_i) begin
        for (int lane = 0; lane < 4; lane++) begin
            // Each lane only moves when its own mask bit is set
            if (port0_write_i && port0_byte_write_i[lane]) begin
                mem_array[port0_address_i][lane*8 +: 8] <= port0_data_i[lane*8 +: 8];
            end
        end
    end

    // --------------------
    // Registered read
    // --------------------

    // The output register holds its last word while the bank is idle
    always_ff @(posedge clk_i) begin
        if (port1_read_i) begin
            port1_data_o <= mem_array[port1_address_i];
        end
    end

endmodule

//--- design/data_cache_block.sv
/*
 * Banked data block of the L1 data cache. The bank select of each access
 * is decoded into per-bank enables, so only one bank toggles per access.
 * Read data comes back one cycle late and is picked by the registered
 * bank select of the read.
 */

`timescale 1ns/1ps

`include "data_memory_macros.svh"

module data_cache_block
    import data_memory_pkg::*;
(
    input  logic        clk_i,
    input  bank_write_t write_i,
    input  bank_read_t  read_i,
    output logic [31:0] rdata_o
);

    logic [`DCACHE_BANKS-1:0]       port0_enable;
    logic [`DCACHE_BANKS-1:0]       port1_enable;
    logic [`DCACHE_BANKS-1:0][31:0] bank_rdata;
    bank_select_t                   read_select_q;

    // --------------------
    // Bank decode
    // --------------------

    always_comb begin
        port0_enable = '0;
        port1_enable = '0;
        for (int bank = 0; bank < `DCACHE_BANKS; bank++) begin
            port0_enable[bank] = (write_i.bank_select == BANK_SEL_W'(bank));
            port1_enable[bank] = (read_i.bank_select == BANK_SEL_W'(bank));
        end
    end

    // --------------------
    // Bank array
    // --------------------

    // Address, mask and data fan out to all banks, only the enables differ
    for (genvar bank = 0; bank < `DCACHE_BANKS; bank++) begin : gen_bank
        data_memory_bank data_memory_bank_inst (
            .clk_i              (clk_i),
            .port0_write_i      (write_i.write & port0_enable[bank]),
            .port0_byte_write_i (write_i.byte_write),
            .port0_address_i    (write_i.index),
            .port0_data_i       (write_i.data),
            .port1_read_i       (read_i.read & port1_enable[bank]),
            .port1_address_i    (read_i.index),
            .port1_data_o       (bank_rdata[bank])
        );
    end

    // The selected bank answers a cycle later, so its number is kept
    always_ff @(posedge clk_i) begin
        read_select_q <= read_i.bank_select;
    end

    assign rdata_o = bank_rdata[read_select_q];

endmodule

//--- design/cache_access_unit.sv
/*
 * Front end of the data cache. Decodes each accepted request into a bank
 * write or bank read plus a load descriptor for the response queue, and
 * aligns store data into its byte lanes. Loads are only accepted while a
 * queue slot is free, tracked with a credit counter.
 */

`timescale 1ns/1ps

`include "data_memory_macros.svh"

module cache_access_unit
    import data_memory_pkg::*;
(
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        req_valid_i,
    input  mem_req_t    req_i,
    output logic        req_ready_o,
    input  logic        slot_credit_i,
    output bank_write_t write_o,
    output bank_read_t  read_o,
    output load_desc_t  load_o
);

    localparam int SLOT_CNT_W = $clog2(`LOAD_QUEUE_DEPTH + 1);

    logic                  is_load;
    logic                  is_byte;
    logic                  is_half;
    logic                  req_accept;
    logic                  load_accept;
    logic [1:0]            offset;
    byte_write_t           byte_mask;
    logic [31:0]           store_data;
    logic [SLOT_CNT_W-1:0] slot_credits_q;

    // --------------------
    // Opcode decode
    // --------------------

    always_comb begin
        is_load = 1'b0;
        is_byte = 1'b0;
        is_half = 1'b0;
        unique case (req_i.op)
            OP_LB, OP_LBU: begin
                is_load = 1'b1;
                is_byte = 1'b1;
            end
            OP_LH, OP_LHU: begin
                is_load = 1'b1;
                is_half = 1'b1;
            end
            OP_LW: is_load = 1'b1;
            OP_SB: is_byte = 1'b1;
            OP_SH: is_half = 1'b1;
            default: ;
        endcase
    end

    assign offset = req_i.addr[1:0];

    // --------------------
    // Byte mask and store alignment
    // --------------------

    // Offset bits below the access size play no part in the lane choice
    always_comb begin
        if (is_byte) begin
            byte_mask  = 4'b0001 << offset;
            store_data = {4{req_i.wdata[7:0]}};
        end else if (is_half) begin
            byte_mask  = offset[1] ? 4'b1100 : 4'b0011;
            store_data = {2{req_i.wdata[15:0]}};
        end else begin
            byte_mask  = 4'b1111;
            store_data = req_i.wdata;
        end
    end

    // A store never waits, a load needs a free slot in the queue
    assign req_ready_o = !is_load || (slot_credits_q != '0);
    assign req_accept  = req_valid_i && req_ready_o;
    assign load_accept = req_accept && is_load;

    // Word index and bank come straight from the address fields
    assign write_o.write       = req_accept && !is_load;
    assign write_o.bank_select = req_i.addr[2 +: BANK_SEL_W];
    assign write_o.index       = req_i.addr[ADDR_W-1 -: INDEX_W];
    assign write_o.byte_write  = byte_mask;
    assign write_o.data        = store_data;

    assign read_o.read        = load_accept;
    assign read_o.bank_select = req_i.addr[2 +: BANK_SEL_W];
    assign read_o.index       = req_i.addr[ADDR_W-1 -: INDEX_W];

    assign load_o.valid  = load_accept;
    assign load_o.op     = req_i.op;
    assign load_o.offset = offset;

    // --------------------
    // Load slot credits
    // --------------------

    // A slot stays reserved from acceptance until its response has left
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            slot_credits_q <= SLOT_CNT_W'(`LOAD_QUEUE_DEPTH);
        end else begin
            unique case ({load_accept, slot_credit_i})
                2'b10:   slot_credits_q <= slot_credits_q - 1'b1;
                2'b01:   slot_credits_q <= slot_credits_q + 1'b1;
                default: slot_credits_q <= slot_credits_q;
            endcase
        end
    end

endmodule

//--- design/load_response_queue.sv
/*
 * Return path for loads. The descriptor of each load is held for one
 * cycle until its word arrives from the data block, then the byte, half
 * or word is extracted, extended and pushed into an in-order FIFO. The
 * FIFO drains one response per cycle while response credits remain.
 */

`timescale 1ns/1ps

`include "data_memory_macros.svh"

module load_response_queue
    import data_memory_pkg::*;
(
    input  logic        clk_i,
    input  logic        reset_i,
    input  load_desc_t  load_i,
    input  logic [31:0] rdata_i,
    output logic        slot_credit_o,
    input  logic        resp_credit_i,
    output logic        resp_valid_o,
    output logic [31:0] resp_data_o
);

    localparam int PTR_W    = $clog2(`LOAD_QUEUE_DEPTH);
    localparam int CNT_W    = $clog2(`LOAD_QUEUE_DEPTH + 1);
    localparam int CREDIT_W = $clog2(`RESP_CREDIT_INIT + `LOAD_QUEUE_DEPTH + 1);

    load_desc_t           desc_q;
    logic [7:0]           sel_byte;
    logic [15:0]          sel_half;
    logic [31:0]          load_data;
    logic                 push;
    logic                 pop;
    logic [31:0]          fifo_mem [`LOAD_QUEUE_DEPTH];
    logic [PTR_W-1:0]     wr_ptr_q;
    logic [PTR_W-1:0]     rd_ptr_q;
    logic [CNT_W-1:0]     count_q;
    logic [CREDIT_W-1:0]  credits_q;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(`LOAD_QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Descriptor lines up with the word the data block returns next cycle
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            desc_q <= '0;
        end else begin
            desc_q <= load_i;
        end
    end

    // --------------------
    // Extraction
    // --------------------

    assign sel_byte = rdata_i[{desc_q.offset, 3'b000} +: 8];
    // Half loads look only at the upper offset bit
    assign sel_half = desc_q.offset[1] ? rdata_i[31:16] : rdata_i[15:0];

    always_comb begin
        unique case (desc_q.op)
            OP_LB:   load_data = {{24{sel_byte[7]}}, sel_byte};
            OP_LBU:  load_data = {24'b0, sel_byte};
            OP_LH:   load_data = {{16{sel_half[15]}}, sel_half};
            OP_LHU:  load_data = {16'b0, sel_half};
            default: load_data = rdata_i;
        endcase
    end

    // --------------------
    // Response FIFO
    // --------------------

    // Overflow cannot happen since every push had a slot reserved upstream
    assign push = desc_q.valid;
    assign pop  = (count_q != '0) && (credits_q != '0);

    always_ff @(posedge clk_i) begin
        if (push) begin
            fifo_mem[wr_ptr_q] <= load_data;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
            if (pop) rd_ptr_q <= next_ptr(rd_ptr_q);
            unique case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Each response spends a credit, each incoming pulse returns one
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            credits_q <= CREDIT_W'(`RESP_CREDIT_INIT);
        end else begin
            unique case ({pop, resp_credit_i})
                2'b10:   credits_q <= credits_q - 1'b1;
                2'b01:   credits_q <= credits_q + 1'b1;
                default: credits_q <= credits_q;
            endcase
        end
    end

    assign resp_valid_o  = pop;
    assign resp_data_o   = fifo_mem[rd_ptr_q];
    assign slot_credit_o = pop;

endmodule

//--- design/data_cache_subsystem.sv
/*
 * Top level of the data array side of the L1 data cache. Requests enter
 * the access unit, which drives the banked data block, and load results
 * come back in order through the response queue under credit control.
 */

`timescale 1ns/1ps

module data_cache_subsystem
    import data_memory_pkg::*;
(
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        req_valid_i,
    input  mem_req_t    req_i,
    output logic        req_ready_o,
    input  logic        resp_credit_i,
    output logic        resp_valid_o,
    output logic [31:0] resp_data_o
);

    bank_write_t bank_write;
    bank_read_t  bank_read;
    load_desc_t  load_desc;
    logic        slot_credit;
    logic [31:0] rdata;

    // --------------------
    // Request side
    // --------------------

    cache_access_unit cache_access_unit_inst (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .req_valid_i   (req_valid_i),
        .req_i         (req_i),
        .req_ready_o   (req_ready_o),
        .slot_credit_i (slot_credit),
        .write_o       (bank_write),
        .read_o        (bank_read),
        .load_o        (load_desc)
    );

    data_cache_block data_cache_block_inst (
        .clk_i   (clk_i),
        .write_i (bank_write),
        .read_i  (bank_read),
        .rdata_o (rdata)
    );

    // --------------------
    // Response side
    // --------------------

    load_response_queue load_response_queue_inst (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .load_i        (load_desc),
        .rdata_i       (rdata),
        .slot_credit_o (slot_credit),
        .resp_credit_i (resp_credit_i),
        .resp_valid_o  (resp_valid_o),
        .resp_data_o   (resp_data_o)
    );

endmodule

//--- tb/tb_data_cache_subsystem.sv
/*
 * Self-checking testbench for the data cache subsystem. Drives loads and
 * stores into the top level and keeps a byte-wide reference memory. The
 * response data, the request handshake and the response credit loop are
 * checked by assertions that sample on the falling clock edge.
 * Compile with build.f, top module tb_data_cache_subsystem.
 */

`timescale 1ns/1ps

`include "data_memory_macros.svh"

module tb_data_cache_subsystem
    import data_memory_pkg::*;
();

    // How the outside world hands response credits back
    localparam int CREDIT_HOLD   = 0;
    localparam int CREDIT_NOW    = 1;
    localparam int CREDIT_RANDOM = 2;

    localparam int WORDS        = 1 << (ADDR_W - 2);
    localparam int ACCEPT_LIMIT = 100;
    localparam int DRAIN_LIMIT  = 200;

    // Cycle budgets per test add up to the watchdog time
    localparam int BUDGET_PRELOAD  = WORDS + 44;
    localparam int BUDGET_WORD     = 20;
    localparam int BUDGET_SUBWORD  = 80;
    localparam int BUDGET_BANKS    = 30;
    localparam int BUDGET_BACKPRES = 60;
    localparam int BUDGET_RANDOM   = 1600;
    localparam int WATCHDOG_NS     = (BUDGET_PRELOAD + BUDGET_WORD + BUDGET_SUBWORD
                                      + BUDGET_BANKS + BUDGET_BACKPRES + BUDGET_RANDOM) * 4
                                     + 400;

    logic        clk_i         = 1'b0;
    logic        reset_i       = 1'b1;
    logic        req_valid_i   = 1'b0;
    mem_req_t    req_i         = '0;
    logic        resp_credit_i = 1'b0;
    logic        req_ready_o;
    logic        resp_valid_o;
    logic [31:0] resp_data_o;

    // Reference model and scoreboard state
    logic [7:0]  ref_mem [1 << ADDR_W];
    logic [31:0] exp_data [$];
    int          exp_cycle [$];
    int          cycle_count          = 0;
    int          resp_credit_avail    = `RESP_CREDIT_INIT;
    int          responses_seen       = 0;
    int          credits_returned     = 0;
    int          credit_mode          = CREDIT_NOW;
    int          error_count          = 0;
    int          test_errors_at_start = 0;
    int          test_number          = 0;
    int          tests_passed         = 0;
    int          tests_failed         = 0;

    // Stimulus and credit timing draw from separate streams of the same seed
    logic [31:0] stim_state   = 32'he0a25e6d;
    logic [31:0] credit_state = 32'he0a25e6d;

    data_cache_subsystem data_cache_subsystem_inst (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .req_valid_i   (req_valid_i),
        .req_i         (req_i),
        .req_ready_o   (req_ready_o),
        .resp_credit_i (resp_credit_i),
        .resp_valid_o  (resp_valid_o),
        .resp_data_o   (resp_data_o)
    );

    initial begin
        forever #2 clk_i = ~clk_i;
    end

    // --------------------
    // Helpers
    // --------------------

    function automatic logic [31:0] next_random(inout logic [31:0] state);
        state = state * 32'd1664525 + 32'd1013904223;
        return state;
    endfunction

    function automatic int access_size(input mem_op_t op);
        case (op)
            OP_LB, OP_LBU, OP_SB: return 1;
            OP_LH, OP_LHU, OP_SH: return 2;
            default:              return 4;
        endcase
    endfunction

    function automatic logic is_load_op(input mem_op_t op);
        return op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
    endfunction

    // Every bit of the word address shows up in its preload word
    function automatic logic [31:0] fill_word(input int word);
        logic [7:0] w;
        w = word[7:0];
        return {~w, w ^ 8'h3c, w + 8'h11, w};
    endfunction

    // Stores are little endian and drop the offset bits below the access size
    function automatic void apply_store(input mem_op_t op, input logic [ADDR_W-1:0] addr,
                                        input logic [31:0] wdata);
        int                size;
        logic [ADDR_W-1:0] base;
        size = access_size(op);
        base = addr & ~ADDR_W'(size - 1);
        for (int i = 0; i < size; i++) begin
            ref_mem[base + i] = wdata[8*i +: 8];
        end
    endfunction

    function automatic logic [31:0] expected_load(input mem_op_t op,
                                                  input logic [ADDR_W-1:0] addr);
        int                size;
        logic [ADDR_W-1:0] base;
        logic [31:0]       value;
        size  = access_size(op);
        base  = addr & ~ADDR_W'(size - 1);
        value = '0;
        for (int i = 0; i < size; i++) begin
            value[8*i +: 8] = ref_mem[base + i];
        end
        // Only the signed loads extend, the unsigned ones keep the zeros
        if (op == OP_LB) begin
            value = {{24{value[7]}}, value[7:0]};
        end else if (op == OP_LH) begin
            value = {{16{value[15]}}, value[15:0]};
        end
        return value;
    endfunction

    task automatic report_mismatch(input string signal, input logic [31:0] expected,
                                   input logic [31:0] actual);
        error_count++;
        $display("[ERROR] %0d ns: %s expected 0x%08h, got 0x%08h",
                 $time, signal, expected, actual);
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("Failure at %0d ns: %s", $time, what);
    endtask

    // --------------------
    // Scoreboard
    // --------------------

    always @(negedge clk_i) begin
        logic ready_expected;
        logic load_request;
        if (!reset_i) begin
            cycle_count++;
            load_request   = is_load_op(req_i.op);
            // Loads stall only while every queue slot is reserved
            ready_expected = !(load_request && exp_data.size() >= `LOAD_QUEUE_DEPTH);
            assert (req_ready_o === ready_expected)
                else report_mismatch("req_ready_o", {31'd0, ready_expected}, {31'd0, req_ready_o});
            if (resp_valid_o === 1'b1) begin
                responses_seen++;
                assert (resp_credit_avail > 0)
                    else report_failure("response sent while the queue held no response credit");
                assert (exp_data.size() != 0)
                    else report_failure("response sent with no load outstanding");
                if (exp_data.size() != 0) begin
                    assert (resp_data_o === exp_data[0])
                        else report_mismatch("resp_data_o", exp_data[0], resp_data_o);
                    assert (cycle_count - exp_cycle[0] >= 2)
                        else report_failure($sformatf("response came %0d cycles after its load",
                                                      cycle_count - exp_cycle[0]));
                    void'(exp_data.pop_front());
                    void'(exp_cycle.pop_front());
                end
                resp_credit_avail--;
            end
            if (resp_credit_i) begin
                resp_credit_avail++;
            end
            // The load reads memory as it stands at acceptance
            if (req_valid_i && req_ready_o) begin
                if (load_request) begin
                    exp_data.push_back(expected_load(req_i.op, req_i.addr));
                    exp_cycle.push_back(cycle_count);
                end else begin
                    apply_store(req_i.op, req_i.addr, req_i.wdata);
                end
            end
        end
    end

    // The outside returns one credit per response it has consumed
    always @(posedge clk_i) begin
        logic [31:0] roll;
        logic        give;
        give = 1'b0;
        if (!reset_i && responses_seen > credits_returned) begin
            if (credit_mode == CREDIT_NOW) begin
                give = 1'b1;
            end else if (credit_mode == CREDIT_RANDOM) begin
                roll = next_random(credit_state);
                give = (roll[25:24] == 2'b00);
            end
        end
        if (give) begin
            credits_returned++;
        end
        resp_credit_i <= give;
    end

    // --------------------
    // Stimulus tasks
    // --------------------

    // Called right after a rising edge, returns right after one
    task automatic send_req(input mem_op_t op, input logic [ADDR_W-1:0] addr,
                            input logic [31:0] wdata);
        int waited;
        waited = 0;
        req_valid_i <= 1'b1;
        req_i       <= '{op: op, addr: addr, wdata: wdata};
        @(negedge clk_i);
        while (!req_ready_o && waited < ACCEPT_LIMIT) begin
            waited++;
            @(negedge clk_i);
        end
        if (!req_ready_o) begin
            report_failure($sformatf("%s request to 0x%03h was not accepted within %0d cycles",
                                     op.name(), addr, ACCEPT_LIMIT));
        end
        @(posedge clk_i);
        req_valid_i <= 1'b0;
    endtask

    // Offers a load for a fixed time without waiting for acceptance
    task automatic present_load(input logic [ADDR_W-1:0] addr, input int cycles);
        req_valid_i <= 1'b1;
        req_i       <= '{op: OP_LW, addr: addr, wdata: 32'h0};
        repeat (cycles) @(posedge clk_i);
        req_valid_i <= 1'b0;
    endtask

    task automatic set_credit_mode(input int mode);
        @(negedge clk_i);
        credit_mode = mode;
        @(posedge clk_i);
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while ((exp_data.size() != 0 || responses_seen != credits_returned)
               && waited < DRAIN_LIMIT) begin
            waited++;
            @(negedge clk_i);
        end
        if (exp_data.size() != 0) begin
            report_failure($sformatf("%0d responses still missing after %0d cycles",
                                     exp_data.size(), DRAIN_LIMIT));
        end
        @(posedge clk_i);
    endtask

    task automatic start_test();
        test_number++;
        test_errors_at_start = error_count;
    endtask

    task automatic finish_test(input string name);
        if (error_count == test_errors_at_start) begin
            tests_passed++;
            $display("Test %0d %s: passed", test_number, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", test_number, name,
                     error_count - test_errors_at_start);
        end
    endtask

    // --------------------
    // Test sequence
    // --------------------

    initial begin
        logic [31:0]        r;
        logic [ADDR_W-1:0]  base;
        logic [INDEX_W-1:0] index;
        mem_op_t            op;

        repeat (2) @(posedge clk_i);
        reset_i <= 1'b0;

        // Idle outputs after reset, then every word gets a known value
        start_test();
        @(negedge clk_i);
        assert (req_ready_o === 1'b1)
            else report_mismatch("req_ready_o", 32'd1, {31'd0, req_ready_o});
        assert (resp_valid_o === 1'b0)
            else report_mismatch("resp_valid_o", 32'd0, {31'd0, resp_valid_o});
        @(posedge clk_i);
        for (int w = 0; w < WORDS; w++) begin
            send_req(OP_SW, ADDR_W'(w * 4), fill_word(w));
        end
        finish_test("reset state and preload");

        start_test();
        base = ADDR_W'(next_random(stim_state) >> 12);
        send_req(OP_SW, base, next_random(stim_state));
        send_req(OP_LW, base, 32'h0);
        wait_idle();
        finish_test("word store and load");

        // Word ends up as 8a01_7faa, with negative and positive lanes
        start_test();
        base = ADDR_W'(next_random(stim_state) >> 12) & ~ADDR_W'(3);
        send_req(OP_SW, base + ADDR_W'(2), 32'h5555_aaaa);
        send_req(OP_SB, base + ADDR_W'(1), 32'h1234_567f);
        send_req(OP_SH, base + ADDR_W'(3), 32'hdead_8a01);
        for (int code = 0; code < 5; code++) begin
            for (int off = 0; off < 4; off++) begin
                send_req(mem_op_t'(code), base + ADDR_W'(off), 32'h0);
            end
        end
        wait_idle();
        finish_test("sub-word merge and extension");

        start_test();
        index = INDEX_W'(next_random(stim_state) >> 16);
        for (int bank = 0; bank < `DCACHE_BANKS; bank++) begin
            send_req(OP_SW, {index, BANK_SEL_W'(bank), 2'b00}, next_random(stim_state));
        end
        for (int bank = 0; bank < `DCACHE_BANKS; bank++) begin
            send_req(OP_LW, {index, BANK_SEL_W'(bank), 2'b00}, 32'h0);
        end
        wait_idle();
        finish_test("independent banks");

        // The initial credits drain two loads and the rest fill the FIFO
        start_test();
        set_credit_mode(CREDIT_HOLD);
        base = ADDR_W'(next_random(stim_state) >> 12);
        for (int n = 0; n < `RESP_CREDIT_INIT + `LOAD_QUEUE_DEPTH; n++) begin
            send_req(OP_LW, base + ADDR_W'(4 * n), 32'h0);
        end
        present_load(base, 6);
        send_req(OP_SB, base + ADDR_W'(5), 32'h0000_00c6);
        set_credit_mode(CREDIT_NOW);
        send_req(OP_LW, base + ADDR_W'(4), 32'h0);
        wait_idle();
        finish_test("back-pressure");

        start_test();
        set_credit_mode(CREDIT_RANDOM);
        for (int n = 0; n < 200; n++) begin
            r    = next_random(stim_state);
            op   = mem_op_t'(r[31:29]);
            base = r[21:12];
            if (r[5:4] == 2'b00) begin
                @(posedge clk_i);
            end
            send_req(op, base, next_random(stim_state));
        end
        wait_idle();
        finish_test("random mix");

        $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- build.f
+incdir+design
design/data_memory_pkg.sv
design/data_memory_bank.sv
design/data_cache_block.sv
design/cache_access_unit.sv
design/load_response_queue.sv
design/data_cache_subsystem.sv
tb/tb_data_cache_subsystem.sv

//--- Bender.yml
package:
  name: data_cache_subsystem

sources:
  - include_dirs:
      - design
    files:
      - design/data_memory_pkg.sv
      - design/data_memory_bank.sv
      - design/data_cache_block.sv
      - design/cache_access_unit.sv
      - design/load_response_queue.sv
      - design/data_cache_subsystem.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/tb_data_cache_subsystem.sv
